//--- hdl/noc_pkg.sv
package noc_pkg;

   // Tile coordinate widths of the mesh.
   localparam int X_CORD_W = 3;
   localparam int Y_CORD_W = 3;

   // Number of body flits that follow a header. A packet carries 0 to 7 of them.
   localparam int LEN_W = 3;

   localparam int FLIT_W = 16;

   // Whatever the routing fields leave over in a header word.
   localparam int HDR_PAYLOAD_W = FLIT_W - X_CORD_W - Y_CORD_W - LEN_W;

   // Header layout with the destination X in the least significant bits.
   typedef struct packed
   {
      logic [HDR_PAYLOAD_W-1:0] hdr_payload;
      logic [LEN_W-1:0]         len;
      logic [Y_CORD_W-1:0]      dest_y;
      logic [X_CORD_W-1:0]      dest_x;
   } flit_hdr_s;

   // One link word. It is a header at a packet boundary and raw payload otherwise.
   typedef union packed
   {
      flit_hdr_s         hdr;
      logic [FLIT_W-1:0] body;
   } flit_u;

endpackage : noc_pkg

//--- hdl/route_pkg.sv
package route_pkg;

   // Local, west, east, north and south.
   localparam int NUM_PORTS = 5;
   localparam int DIR_BITS  = $clog2(NUM_PORTS);

   // Direction codes double as port indices throughout the router.
   typedef enum logic [DIR_BITS-1:0]
   {
      DIR_P = 0,
      DIR_W = 1,
      DIR_E = 2,
      DIR_N = 3,
      DIR_S = 4
   } dir_e;

   // One bit per port, indexed by dir_e. Holds at most one set bit.
   typedef logic [NUM_PORTS-1:0] port_set_t;

endpackage : route_pkg

//--- hdl/wh_flit_counter.sv
`timescale 1ns/1ps

module wh_flit_counter
(
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  logic                      load_i,
   input  logic [noc_pkg::LEN_W-1:0] len_i,
   input  logic                      dec_i,
   output logic                      at_boundary_o
);
   import noc_pkg::*;

   logic [LEN_W-1:0] count_q;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         count_q <= '0;
      end
      else if (load_i)
      begin
         count_q <= len_i;
      end
      else if (dec_i && (count_q != '0))
      begin
         count_q <= count_q - 1'b1;
      end
   end

   // Nothing left of the current packet, so the next flit out is a header.
   assign at_boundary_o = (count_q == '0);

endmodule : wh_flit_counter

//--- hdl/wh_input_port.sv
`timescale 1ns/1ps

module wh_input_port
#(
   parameter int FIFO_DEPTH = 2
)
(
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   input  logic [noc_pkg::X_CORD_W-1:0] my_x_i,
   input  logic [noc_pkg::Y_CORD_W-1:0] my_y_i,
   input  noc_pkg::flit_u               data_i,
   input  logic                         valid_i,
   output logic                         ready_o,
   input  logic                         pop_i,
   output noc_pkg::flit_u               head_o,
   output logic                         head_valid_o,
   output logic                         head_is_hdr_o,
   output logic                         head_is_tail_o,
   output route_pkg::port_set_t         route_o
);
   import noc_pkg::*;
   import route_pkg::*;

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   logic [FLIT_W-1:0] mem_q [FIFO_DEPTH];
   logic [PTR_W-1:0]  wr_ptr_q;
   logic [PTR_W-1:0]  rd_ptr_q;
   logic [CNT_W-1:0]  count_q;
   logic              push;
   logic              pop;
   logic              last_body;
   logic [LEN_W-1:0]  rest_len;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(FIFO_DEPTH - 1))
      begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign ready_o = (count_q != CNT_W'(FIFO_DEPTH));
   assign push    = valid_i & ready_o;
   assign pop     = pop_i & head_valid_o;

   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         mem_q[wr_ptr_q] <= data_i.body;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         end
         if (pop)
         begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         end
         count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
      end
   end

   assign head_o.body  = mem_q[rd_ptr_q];
   assign head_valid_o = (count_q != '0);

   // The first counter tracks the body flits still to leave. The second one runs
   // one flit behind it and so flags the last body flit while it sits at the head.
   assign rest_len = (head_o.hdr.len == '0) ? '0 : head_o.hdr.len - 1'b1;

   wh_flit_counter u_pkt_cnt
   (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .load_i        (pop & head_is_hdr_o),
      .len_i         (head_o.hdr.len),
      .dec_i         (pop & ~head_is_hdr_o),
      .at_boundary_o (head_is_hdr_o)
   );

   wh_flit_counter u_last_cnt
   (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .load_i        (pop & head_is_hdr_o),
      .len_i         (rest_len),
      .dec_i         (pop & ~head_is_hdr_o),
      .at_boundary_o (last_body)
   );

   assign head_is_tail_o = head_is_hdr_o ? (head_o.hdr.len == '0) : last_body;

   // XY order. Only meaningful while the head is a header.
   always_comb
   begin
      route_o = '0;
      if (head_o.hdr.dest_x > my_x_i)
      begin
         route_o[DIR_E] = 1'b1;
      end
      else if (head_o.hdr.dest_x < my_x_i)
      begin
         route_o[DIR_W] = 1'b1;
      end
      else if (head_o.hdr.dest_y > my_y_i)
      begin
         route_o[DIR_S] = 1'b1;
      end
      else if (head_o.hdr.dest_y < my_y_i)
      begin
         route_o[DIR_N] = 1'b1;
      end
      else
      begin
         route_o[DIR_P] = 1'b1;
      end
   end

endmodule : wh_input_port

//--- hdl/wh_output_ctrl.sv
`timescale 1ns/1ps

module wh_output_ctrl
#(
   parameter route_pkg::dir_e OUT_DIR = route_pkg::DIR_P
)
(
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  route_pkg::port_set_t req_i,
   input  logic                 tail_pop_i,
   output route_pkg::port_set_t grant_o
);
   import route_pkg::*;

   typedef enum logic
   {
      IDLE   = 1'b0,
      LOCKED = 1'b1
   } state_e;

   state_e    state_q;
   port_set_t grant_q;
   port_set_t pick;
   dir_e      pick_dir;
   dir_e      last_q;

   // Round robin. The search starts at the port after the previous winner,
   // so walking backwards lets the nearest requester overwrite the others.
   always_comb
   begin
      int idx;
      idx      = 0;
      pick     = '0;
      pick_dir = last_q;
      for (int k = NUM_PORTS; k >= 1; k--)
      begin
         idx = (int'(last_q) + k) % NUM_PORTS;
         if (req_i[idx])
         begin
            pick      = '0;
            pick[idx] = 1'b1;
            pick_dir  = dir_e'(idx);
         end
      end
   end

   // An idle output grants straight away, without waiting a cycle.
   assign grant_o = (state_q == LOCKED) ? grant_q : pick;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q <= IDLE;
         grant_q <= '0;
         last_q  <= OUT_DIR;
      end
      else
      begin
         case (state_q)
            IDLE:
            begin
               if (|req_i)
               begin
                  last_q <= pick_dir;
                  // A header-only packet that leaves at once needs no lock.
                  if (!tail_pop_i)
                  begin
                     state_q <= LOCKED;
                     grant_q <= pick;
                  end
               end
            end
            LOCKED:
            begin
               if (tail_pop_i)
               begin
                  state_q <= IDLE;
                  grant_q <= '0;
               end
            end
            default:
            begin
               state_q <= IDLE;
            end
         endcase
      end
   end

endmodule : wh_output_ctrl

//--- hdl/wh_crossbar.sv
`timescale 1ns/1ps

module wh_crossbar
(
   input  route_pkg::port_set_t [route_pkg::NUM_PORTS-1:0] grant_i,
   input  noc_pkg::flit_u       [route_pkg::NUM_PORTS-1:0] head_i,
   input  logic                 [route_pkg::NUM_PORTS-1:0] head_valid_i,
   input  logic                 [route_pkg::NUM_PORTS-1:0] link_ready_i,
   output noc_pkg::flit_u       [route_pkg::NUM_PORTS-1:0] link_data_o,
   output logic                 [route_pkg::NUM_PORTS-1:0] link_valid_o,
   output logic                 [route_pkg::NUM_PORTS-1:0] pop_o
);
   import noc_pkg::*;
   import route_pkg::*;

   // Grants are one-hot per output and an input is granted by one output at most,
   // so each output and each pop has a single source.
   always_comb
   begin
      link_data_o  = '0;
      link_valid_o = '0;
      pop_o        = '0;
      for (int o = 0; o < NUM_PORTS; o++)
      begin
         for (int i = 0; i < NUM_PORTS; i++)
         begin
            if (grant_i[o][i])
            begin
               link_data_o[o]  = head_i[i];
               link_valid_o[o] = head_valid_i[i];
               pop_o[i]        = head_valid_i[i] & link_ready_i[o];
            end
         end
      end
   end

endmodule : wh_crossbar

//--- hdl/wh_router.sv
`timescale 1ns/1ps

module wh_router
#(
   parameter int FIFO_DEPTH = 2
)
(
   input  logic                                     clk_i,
   input  logic                                     arst_n_i,
   input  logic [noc_pkg::X_CORD_W-1:0]             my_x_i,
   input  logic [noc_pkg::Y_CORD_W-1:0]             my_y_i,
   input  noc_pkg::flit_u [route_pkg::NUM_PORTS-1:0] link_data_i,
   input  logic           [route_pkg::NUM_PORTS-1:0] link_valid_i,
   output logic           [route_pkg::NUM_PORTS-1:0] link_ready_o,
   output noc_pkg::flit_u [route_pkg::NUM_PORTS-1:0] link_data_o,
   output logic           [route_pkg::NUM_PORTS-1:0] link_valid_o,
   input  logic           [route_pkg::NUM_PORTS-1:0] link_ready_i
);
   import noc_pkg::*;
   import route_pkg::*;

   flit_u     [NUM_PORTS-1:0] head;
   logic      [NUM_PORTS-1:0] head_valid;
   logic      [NUM_PORTS-1:0] head_is_hdr;
   logic      [NUM_PORTS-1:0] head_is_tail;
   logic      [NUM_PORTS-1:0] pop;
   logic      [NUM_PORTS-1:0] tail_pop;
   port_set_t [NUM_PORTS-1:0] route;
   port_set_t [NUM_PORTS-1:0] req;
   port_set_t [NUM_PORTS-1:0] grant;

   for (genvar i = 0; i < NUM_PORTS; i++)
   begin : g_in
      wh_input_port
      #(
         .FIFO_DEPTH (FIFO_DEPTH)
      )
      u_in_port
      (
         .clk_i          (clk_i),
         .arst_n_i       (arst_n_i),
         .my_x_i         (my_x_i),
         .my_y_i         (my_y_i),
         .data_i         (link_data_i[i]),
         .valid_i        (link_valid_i[i]),
         .ready_o        (link_ready_o[i]),
         .pop_i          (pop[i]),
         .head_o         (head[i]),
         .head_valid_o   (head_valid[i]),
         .head_is_hdr_o  (head_is_hdr[i]),
         .head_is_tail_o (head_is_tail[i]),
         .route_o        (route[i])
      );
   end

   for (genvar o = 0; o < NUM_PORTS; o++)
   begin : g_out
      // Only a waiting header asks for an output. Body flits follow the lock.
      for (genvar i = 0; i < NUM_PORTS; i++)
      begin : g_req
         assign req[o][i] = head_valid[i] & head_is_hdr[i] & route[i][o];
      end

      assign tail_pop[o] = |(grant[o] & pop & head_is_tail);

      wh_output_ctrl
      #(
         .OUT_DIR (dir_e'(o))
      )
      u_out_ctrl
      (
         .clk_i      (clk_i),
         .arst_n_i   (arst_n_i),
         .req_i      (req[o]),
         .tail_pop_i (tail_pop[o]),
         .grant_o    (grant[o])
      );
   end

   wh_crossbar u_xbar
   (
      .grant_i      (grant),
      .head_i       (head),
      .head_valid_i (head_valid),
      .link_ready_i (link_ready_i),
      .link_data_o  (link_data_o),
      .link_valid_o (link_valid_o),
      .pop_o        (pop)
   );

endmodule : wh_router

//--- verification/wh_router_assertions.sv
`timescale 1ns/1ps

module wh_router_assertions
(
   input logic                                             clk_i,
   input logic                                             arst_n_i,
   input noc_pkg::flit_u       [route_pkg::NUM_PORTS-1:0] out_data_i,
   input logic                 [route_pkg::NUM_PORTS-1:0] out_valid_i,
   input logic                 [route_pkg::NUM_PORTS-1:0] out_ready_i,
   input route_pkg::port_set_t [route_pkg::NUM_PORTS-1:0] grant_i
);
   import route_pkg::*;

   for (genvar o = 0; o < NUM_PORTS; o++)
   begin : g_out
      // A stalled output keeps its flit until the next router takes it.
      a_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         (out_valid_i[o] && !out_ready_i[o]) |=> (out_valid_i[o] && $stable(out_data_i[o])))
      else $error("output %0d changed valid or data while stalled", o);

      a_grant_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         $onehot0(grant_i[o]))
      else $error("output %0d is granted to more than one input", o);
   end

   for (genvar i = 0; i < NUM_PORTS; i++)
   begin : g_in
      logic [NUM_PORTS-1:0] owners;

      for (genvar o = 0; o < NUM_PORTS; o++)
      begin : g_col
         assign owners[o] = grant_i[o][i];
      end

      // An input feeds one output at most.
      a_single_owner: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         $onehot0(owners))
      else $error("input %0d is granted by more than one output", i);
   end

endmodule : wh_router_assertions

bind wh_router wh_router_assertions u_assertions
(
   .clk_i       (clk_i),
   .arst_n_i    (arst_n_i),
   .out_data_i  (link_data_o),
   .out_valid_i (link_valid_o),
   .out_ready_i (link_ready_i),
   .grant_i     (grant)
);

//--- verification/wh_router_tb.sv
`timescale 1ns/1ps

module wh_router_tb;
   import noc_pkg::*;
   import route_pkg::*;

   localparam int          FIFO_DEPTH = 2;
   localparam int          MY_X       = 3;
   localparam int          MY_Y       = 3;
   localparam logic [31:0] SEED       = 32'h2dddfde4;

   logic                  clk = 1'b0;
   logic                  arst_n;
   flit_u [NUM_PORTS-1:0] in_data;
   logic  [NUM_PORTS-1:0] in_valid;
   logic  [NUM_PORTS-1:0] in_ready;
   flit_u [NUM_PORTS-1:0] out_data;
   logic  [NUM_PORTS-1:0] out_valid;
   logic  [NUM_PORTS-1:0] out_ready;

   // Flits still to send per input, and flits expected per output and source.
   logic [FLIT_W-1:0]    tx_q [NUM_PORTS][$];
   logic [FLIT_W-1:0]    exp_q [NUM_PORTS*NUM_PORTS][$];
   int                   cur_src [NUM_PORTS];
   int                   body_left [NUM_PORTS];
   int                   accept_cnt [NUM_PORTS];
   int                   stall_left [NUM_PORTS];
   logic [NUM_PORTS-1:0] in_fire = '0;
   logic [NUM_PORTS-1:0] hold_low = '0;
   logic [NUM_PORTS-1:0] stall_en = '0;
   int                   errors = 0;
   int                   checks = 0;
   int                   tests_run = 0;
   int                   tests_failed = 0;
   int                   flits_sent = 0;
   int                   pkt_id = 0;
   int                   cycles = 0;

   wh_router
   #(
      .FIFO_DEPTH (FIFO_DEPTH)
   )
   u_dut
   (
      .clk_i        (clk),
      .arst_n_i     (arst_n),
      .my_x_i       (X_CORD_W'(MY_X)),
      .my_y_i       (Y_CORD_W'(MY_Y)),
      .link_data_i  (in_data),
      .link_valid_i (in_valid),
      .link_ready_o (in_ready),
      .link_data_o  (out_data),
      .link_valid_o (out_valid),
      .link_ready_i (out_ready)
   );

   always #4 clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (expected !== actual)
      begin
         $display("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual);
         errors++;
      end
   endtask

   // XY order with X first.
   function automatic int route_of(input int dx, input int dy);
      if (dx > MY_X)
         return int'(DIR_E);
      if (dx < MY_X)
         return int'(DIR_W);
      if (dy > MY_Y)
         return int'(DIR_S);
      if (dy < MY_Y)
         return int'(DIR_N);
      return int'(DIR_P);
   endfunction

   task automatic send_packet(input int src, input int dx, input int dy, input int len);
      flit_u             hdr;
      logic [FLIT_W-1:0] body;
      int                sb;
      hdr.hdr.dest_x      = X_CORD_W'(dx);
      hdr.hdr.dest_y      = Y_CORD_W'(dy);
      hdr.hdr.len         = LEN_W'(len);
      hdr.hdr.hdr_payload = HDR_PAYLOAD_W'(pkt_id);
      pkt_id++;
      sb = route_of(dx, dy) * NUM_PORTS + src;
      tx_q[src].push_back(hdr.body);
      exp_q[sb].push_back(hdr.body);
      for (int k = 0; k < len; k++)
      begin
         body = FLIT_W'($urandom);
         tx_q[src].push_back(body);
         exp_q[sb].push_back(body);
      end
      flits_sent += len + 1;
   endtask

   // A header picks the source whose next flit it is. The body that follows must
   // come from that same source, so interleaved packets show up as mismatches.
   task automatic score_flit(input int o, input logic [FLIT_W-1:0] data);
      flit_u f;
      int    src;
      f.body = data;
      src    = -1;
      if (body_left[o] == 0)
      begin
         for (int s = 0; s < NUM_PORTS; s++)
         begin
            if (src < 0 && exp_q[o*NUM_PORTS+s].size() > 0 && exp_q[o*NUM_PORTS+s][0] == data)
               src = s;
         end
         if (src >= 0)
         begin
            cur_src[o]   = src;
            body_left[o] = int'(f.hdr.len);
         end
      end
      else
      begin
         src = cur_src[o];
         body_left[o]--;
      end
      if (src < 0)
      begin
         $display("Output %0d delivered header 0x%h that no input sent there", o, data);
         errors++;
      end
      else if (exp_q[o*NUM_PORTS+src].size() == 0)
      begin
         $display("Output %0d delivered flit 0x%h beyond the end of a packet", o, data);
         errors++;
      end
      else
      begin
         check_value($sformatf("link_data_o[%0d]", o),
                     32'(exp_q[o*NUM_PORTS+src].pop_front()), 32'(data));
      end
   endtask

   function automatic logic drained();
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         if (tx_q[p].size() != 0)
            return 1'b0;
      end
      for (int i = 0; i < NUM_PORTS * NUM_PORTS; i++)
      begin
         if (exp_q[i].size() != 0)
            return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic wait_drain();
      while (!drained())
         @(posedge clk);
      repeat (2) @(posedge clk);
   endtask

   task automatic finish_test(input string name, input int err0);
      tests_run++;
      if (errors != err0)
      begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, errors - err0);
      end
      else
      begin
         $display("%s: ok", name);
      end
   endtask

   task automatic reset_values();
      int err0;
      err0 = errors;
      @(negedge clk);
      check_value("link_valid_o", 32'(0), 32'(out_valid));
      check_value("link_ready_o", 32'((1 << NUM_PORTS) - 1), 32'(in_ready));
      finish_test("reset values", err0);
   endtask

   task automatic local_delivery();
      int err0;
      err0 = errors;
      send_packet(int'(DIR_W), MY_X, MY_Y, 0);
      send_packet(int'(DIR_E), MY_X, MY_Y, 7);
      send_packet(int'(DIR_P), MY_X, MY_Y, 7);
      wait_drain();
      finish_test("local delivery", err0);
   endtask

   task automatic xy_routing();
      int err0;
      err0 = errors;
      send_packet(int'(DIR_P), 5, 3, 2);
      send_packet(int'(DIR_P), 0, 3, 2);
      send_packet(int'(DIR_P), 3, 6, 2);
      send_packet(int'(DIR_P), 3, 1, 2);
      // Off in both X and Y, so it must leave east.
      send_packet(int'(DIR_P), 6, 0, 3);
      wait_drain();
      finish_test("xy routing", err0);
   endtask

   task automatic wormhole_lock();
      int err0;
      err0 = errors;
      send_packet(int'(DIR_W), MY_X, MY_Y, 7);
      send_packet(int'(DIR_N), MY_X, MY_Y, 7);
      send_packet(int'(DIR_S), 5, 2, 6);
      send_packet(int'(DIR_E), 7, 4, 5);
      wait_drain();
      finish_test("wormhole lock", err0);
   endtask

   task automatic backpressure();
      int err0;
      int start;
      int waited;
      err0   = errors;
      start  = accept_cnt[DIR_E];
      waited = 0;
      hold_low[DIR_P] = 1'b1;
      send_packet(int'(DIR_E), MY_X, MY_Y, 7);
      // The local output is held, so the east FIFO fills up and stops taking flits.
      while (in_ready[DIR_E] && waited < 16)
      begin
         @(negedge clk);
         waited++;
      end
      check_value("link_ready_o[2]", 32'(0), 32'(in_ready[DIR_E]));
      check_value("flits accepted on link 2", 32'(FIFO_DEPTH), 32'(accept_cnt[DIR_E] - start));
      hold_low = '0;
      stall_en = '1;
      send_packet(int'(DIR_W), MY_X, MY_Y, 5);
      send_packet(int'(DIR_N), 6, 5, 4);
      send_packet(int'(DIR_P), 1, 6, 3);
      send_packet(int'(DIR_S), 3, 0, 7);
      wait_drain();
      stall_en = '0;
      finish_test("backpressure", err0);
   endtask

   task automatic random_traffic();
      int err0;
      err0 = errors;
      for (int n = 0; n < 40; n++)
      begin
         send_packet(int'($urandom % NUM_PORTS), int'($urandom % 8), int'($urandom % 8),
                     int'($urandom % 8));
      end
      wait_drain();
      finish_test("random traffic", err0);
   endtask

   // Inputs change 1 ns after the rising edge. A flit leaves its queue after the
   // handshake seen at the falling edge has completed on the rising edge.
   initial
   begin
      in_data   = '0;
      in_valid  = '0;
      out_ready = '1;
      for (int p = 0; p < NUM_PORTS; p++)
         stall_left[p] = 0;
      forever
      begin
         @(posedge clk);
         #1;
         for (int p = 0; p < NUM_PORTS; p++)
         begin
            if (in_fire[p] && tx_q[p].size() > 0)
               void'(tx_q[p].pop_front());
            in_valid[p]     = (tx_q[p].size() > 0);
            in_data[p].body = (tx_q[p].size() > 0) ? tx_q[p][0] : '0;
            if (hold_low[p])
            begin
               out_ready[p] = 1'b0;
            end
            else if (stall_left[p] > 0)
            begin
               out_ready[p] = 1'b0;
               stall_left[p]--;
            end
            else if (stall_en[p] && ($urandom % 4 == 0))
            begin
               out_ready[p]  = 1'b0;
               stall_left[p] = int'($urandom_range(6, 2));
            end
            else
            begin
               out_ready[p] = 1'b1;
            end
         end
      end
   end

   // Everything is stable by the falling edge.
   initial
   begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         cur_src[p]    = 0;
         body_left[p]  = 0;
         accept_cnt[p] = 0;
      end
      forever
      begin
         @(negedge clk);
         in_fire = in_valid & in_ready;
         for (int p = 0; p < NUM_PORTS; p++)
         begin
            if (in_fire[p])
               accept_cnt[p]++;
            if (arst_n && out_valid[p] && out_ready[p])
               score_flit(p, out_data[p].body);
         end
      end
   end

   initial
   begin
      while (cycles <= 40 * flits_sent + 2000)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the router stopped delivering flits after %0d cycles", cycles);
      $display(">>> FAIL");
      $finish;
   end

   initial
   begin
      void'($urandom(SEED));
      arst_n = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      arst_n = 1'b1;
      reset_values();
      local_delivery();
      xy_routing();
      wormhole_lock();
      backpressure();
      random_traffic();
      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d flits",
               tests_run, tests_failed, checks, errors, flits_sent);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule : wh_router_tb

//--- flist.f
hdl/noc_pkg.sv
hdl/route_pkg.sv
hdl/wh_flit_counter.sv
hdl/wh_input_port.sv
hdl/wh_output_ctrl.sv
hdl/wh_crossbar.sv
hdl/wh_router.sv
verification/wh_router_assertions.sv
verification/wh_router_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the router testbench with Verilator, runs it and looks for the pass line.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module wh_router_tb
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/Vwh_router_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qxF ">>> PASS"; then
   exit 0
fi
exit 1
